/* mem_init.hex */
// one 32-bit word per line, word index 0 to 63
1300ff00
1301fe04
1302fd08
1303fc0c
1304fb10
1305fa14
1306f918
1307f81c
1308f720
1309f624
130af528
130bf42c
130cf330
130df234
130ef138
130ff03c
1310ef40
1311ee44
1312ed48
1313ec4c
1314eb50
1315ea54
1316e958
1317e85c
1318e760
1319e664
131ae568
131be46c
131ce370
131de274
131ee178
131fe07c
1320df80
1321de84
1322dd88
1323dc8c
1324db90
1325da94
1326d998
1327d89c
1328d7a0
1329d6a4
132ad5a8
132bd4ac
132cd3b0
132dd2b4
132ed1b8
132fd0bc
1330cfc0
1331cec4
1332cdc8
1333cccc
1334cbd0
1335cad4
1336c9d8
1337c8dc
1338c7e0
1339c6e4
133ac5e8
133bc4ec
133cc3f0
133dc2f4
133ec1f8
133fc0fc

/* sim.f */
mem_pkg.sv
cpu_pkg.sv
wait_counter.sv
sram_bank.sv
instr_hold.sv
request_fsm.sv
mem_subsystem.sv
tb_checker.sv
tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f sim.f --top-module tb_mem_subsystem -o sim_bin
./obj_dir/sim_bin > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

/* tb_mem_subsystem.sv */
`timescale 1ns/1ns

module tb_mem_subsystem
    import mem_pkg::*;
    import cpu_pkg::*;
();

    localparam int NUM_STEPS  = 300;
    localparam int WAIT_LIMIT = 50;

    logic     clk = 1'b0;
    logic     rst;
    cpu_req_t cpu_req;
    instr_t   instruction_out;
    word_t    load_data;
    logic     load_valid;
    logic     freeze;
    int       errors;
    int       timeouts;
    int       seed;
    int       n_plain;
    int       n_load;
    int       n_store;

    mem_subsystem u_dut (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .instruction_out (instruction_out),
        .load_data       (load_data),
        .load_valid      (load_valid),
        .freeze          (freeze)
    );

    tb_checker u_check (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .instruction_out (instruction_out),
        .load_data       (load_data),
        .load_valid      (load_valid),
        .freeze          (freeze),
        .errors          (errors)
    );

    always #4 clk = ~clk;

    // random core picks a new pc and data access held for the whole step.
    task automatic drive_step();
        int       op;
        mem_idx_t pc_idx;
        mem_idx_t data_idx;
        pc_idx   = mem_idx_t'($random(seed));
        data_idx = mem_idx_t'($random(seed));
        op       = $unsigned($random(seed)) % 3;
        cpu_req.pc         = addr_t'({pc_idx, 2'b00});
        cpu_req.mem_addr   = addr_t'({data_idx, 2'b00});
        cpu_req.store_data = $random(seed);
        cpu_req.mem_read   = (op == 1);
        cpu_req.mem_write  = (op == 2);
        case (op)
            1: n_load++;
            2: n_store++;
            default: n_plain++;
        endcase
    endtask

    task automatic wait_retire(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (!freeze) begin
                ok = 1'b1;
            end
            n++;
        end
    endtask

    initial begin
        logic ok;
        rst      = 1'b1;
        cpu_req  = '0;
        seed     = 58;
        timeouts = 0;
        n_plain  = 0;
        n_load   = 0;
        n_store  = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_STEPS && timeouts == 0; i++) begin
            drive_step();
            wait_retire(ok);
            if (!ok) begin
                timeouts++;
                $display("timeout: freeze stayed high for %0d cycles in step %0d",
                         WAIT_LIMIT, i);
            end else begin
                @(posedge clk);
                #1;     // pc may change once freeze was low.
            end
        end

        $display("steps plain %0d load %0d store %0d, errors %0d, timeouts %0d",
                 n_plain, n_load, n_store, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ns

module tb_checker
    import mem_pkg::*;
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    input  instr_t   instruction_out,
    input  word_t    load_data,
    input  logic     load_valid,
    input  logic     freeze,
    output int       errors
);

    localparam int FETCH_CYC = WAIT_STATES + 1;
    localparam int PLAIN_LEN = WAIT_STATES + 2;
    localparam int MEM_LEN   = 2 * WAIT_STATES + 4;

    word_t    mirror [MEM_DEPTH];
    int       err_count = 0;
    int       cyc = 0;          // cycle within the current step.
    int       since_low = 0;
    int       step_len = PLAIN_LEN;
    instr_t   held = NOP_INSTR;
    logic     is_load = 1'b0;
    logic     is_store = 1'b0;
    logic     last_cyc;
    mem_idx_t pc_idx = '0;
    mem_idx_t data_idx = '0;
    word_t    st_data = '0;

    assign errors = err_count;

    initial begin
        $readmemh(MEM_INIT_FILE, mirror);
    end

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            err_count++;
            $display("FAILED %s: expected %08h, actual %08h at %0t", name, exp, act, $time);
        end
    endtask

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (rst) begin
            check_word("freeze", 32'h1, {31'b0, freeze});
            check_word("load_valid", 32'h0, {31'b0, load_valid});
            check_word("instruction_out", NOP_INSTR, instruction_out);
            cyc = 0;
            since_low = 0;
        end else begin
            if (cyc == 0) begin
                pc_idx   = cpu_req.pc[MEM_AW+1:2];
                data_idx = cpu_req.mem_addr[MEM_AW+1:2];
                st_data  = cpu_req.store_data;
                is_load  = cpu_req.mem_read;
                is_store = cpu_req.mem_write;
                step_len = (is_load || is_store) ? MEM_LEN : PLAIN_LEN;
            end
            since_low++;
            last_cyc = (cyc == step_len - 1);

            if (cyc < FETCH_CYC) begin
                check_word("instruction_out", NOP_INSTR, instruction_out);
            end else if (cyc == FETCH_CYC) begin
                held = mirror[pc_idx];  // first cycle with the fetched word.
                check_word("instruction_out", held, instruction_out);
            end else begin
                check_word("instruction_out", held, instruction_out);
            end

            check_word("freeze", {31'b0, !last_cyc}, {31'b0, freeze});
            check_word("load_valid", {31'b0, is_load && last_cyc}, {31'b0, load_valid});
            if (is_load && last_cyc) begin
                check_word("load_data", mirror[data_idx], load_data);
            end

            if (!freeze) begin
                if (since_low != step_len) begin
                    err_count++;
                    $display("step length wrong: %0d cycles between freeze lows, %0d expected",
                             since_low, step_len);
                end
                since_low = 0;
            end

            if (last_cyc) begin
                if (is_store) begin
                    mirror[data_idx] = st_data;
                end
                cyc = 0;
            end else begin
                cyc++;
            end
        end
    end

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ns

module mem_subsystem
    import mem_pkg::*;
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    output instr_t   instruction_out,
    output word_t    load_data,
    output logic     load_valid,
    output logic     freeze
);

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     mem_ack;
    word_t    mem_rdata;
    logic     capture;
    logic     show;
    logic     active;

    assign active  = mem_req.rd | mem_req.wr;
    assign mem_rsp = '{ack: mem_ack, rdata: mem_rdata};

    request_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .ack        (mem_rsp.ack),
        .rdata      (mem_rsp.rdata),
        .mem_req    (mem_req),
        .capture    (capture),
        .show       (show),
        .freeze     (freeze),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

    instr_hold u_hold (
        .clk             (clk),
        .rst             (rst),
        .capture         (capture),
        .show            (show),
        .rdata           (mem_rsp.rdata),
        .instruction_out (instruction_out)
    );

    // fixed wait states stand in for the memory timing.
    wait_counter u_wait (
        .clk    (clk),
        .rst    (rst),
        .active (active),
        .ack    (mem_ack)
    );

    sram_bank u_sram (
        .clk     (clk),
        .mem_req (mem_req),
        .ack     (mem_ack),
        .rdata   (mem_rdata)
    );

endmodule

/* request_fsm.sv */
`timescale 1ns/1ns

module request_fsm
    import mem_pkg::*;
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    input  logic     ack,
    input  word_t    rdata,
    output mem_req_t mem_req,
    output logic     capture,
    output logic     show,
    output logic     freeze,
    output word_t    load_data,
    output logic     load_valid
);

    req_state_t state;
    req_state_t state_next;
    logic       mem_op;     // held instruction wants the data port.
    logic       retire;
    logic       load_done;

    assign mem_op = cpu_req.mem_read | cpu_req.mem_write;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                if (ack) begin
                    state_next = EXEC;
                end
            end
            EXEC: begin
                // plain instructions retire here.
                if (mem_op) begin
                    state_next = DATA;
                end else begin
                    state_next = FETCH;
                end
            end
            DATA: begin
                if (ack) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = FETCH;
            end
            default: begin
                state_next = FETCH;
            end
        endcase
    end

    // the single port's address follows the step.
    always_comb begin
        mem_req.addr  = cpu_req.pc;
        mem_req.wdata = cpu_req.store_data;
        mem_req.rd    = 1'b0;
        mem_req.wr    = 1'b0;
        case (state)
            FETCH: begin
                mem_req.rd = 1'b1;
            end
            DATA: begin
                mem_req.addr = cpu_req.mem_addr;
                mem_req.rd   = cpu_req.mem_read;
                mem_req.wr   = cpu_req.mem_write;
            end
            default: begin
                mem_req.rd = 1'b0;  // EXEC and DONE leave the port idle.
                mem_req.wr = 1'b0;
            end
        endcase
    end

    assign capture = (state == FETCH) && ack;
    assign show    = (state != FETCH);

    assign retire = ((state == EXEC) && !mem_op) || (state == DONE);
    assign freeze = !retire;

    assign load_done = (state == DATA) && ack && cpu_req.mem_read;

    // high through DONE only.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            load_data <= rdata;
        end
    end

endmodule

/* instr_hold.sv */
`timescale 1ns/1ns

module instr_hold
    import cpu_pkg::*;
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   capture,
    input  logic   show,
    input  word_t  rdata,
    output instr_t instruction_out
);

    instr_t held;

    // loaded once per step at the fetch ack.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held <= NOP_INSTR;
        end else if (capture) begin
            held <= instr_t'(rdata);
        end
    end

    // the core sees a bubble until the fetch has landed.
    // after that the word stays put through any data access,
    // since rdata is no longer looked at.
    always_comb begin
        if (show) begin
            instruction_out = held;
        end else begin
            instruction_out = NOP_INSTR;
        end
    end

endmodule

/* sram_bank.sv */
`timescale 1ns/1ns

module sram_bank
    import mem_pkg::*;
(
    input  logic     clk,
    input  mem_req_t mem_req,
    input  logic     ack,
    output word_t    rdata
);

    word_t    mem [MEM_DEPTH];
    mem_idx_t idx;
    logic     write_now;

    // word aligned with the upper bits ignored.
    assign idx = mem_req.addr[MEM_AW+1:2];

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    assign write_now = ack && mem_req.wr;

    always_ff @(posedge clk) begin
        if (write_now) begin
            mem[idx] <= mem_req.wdata;
        end
    end

    // async read that the fsm only samples with ack.
    assign rdata = mem[idx];

endmodule

/* wait_counter.sv */
`timescale 1ns/1ns

module wait_counter
    import mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic active,
    output logic ack
);

    wait_cnt_t count;
    logic      at_limit;

    assign at_limit = (count == wait_cnt_t'(WAIT_STATES));

    // first cycle of the level sees zero.
    assign ack = active && at_limit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (!active || ack) begin
            count <= '0;    // request done or ending now.
        end else begin
            count <= count + wait_cnt_t'(1);
        end
    end

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] instr_t;

    localparam instr_t NOP_INSTR = 32'h0000_0000;     // bubble.

    // inputs from the core that stay put while freeze is high.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        mem_read;
        logic        mem_write;
    } cpu_req_t;

    // front-end steps.
    // FETCH waits on the instruction read, EXEC hands it to the core,
    // DATA runs the load or store and DONE retires a memory instruction.
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        DATA,
        DONE
    } req_state_t;

endpackage

/* mem_pkg.sv */
package mem_pkg;

    // memory port widths.
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // 64 words indexed by byte address bits [7:2].
    localparam int MEM_DEPTH = 64;
    localparam int MEM_AW    = 6;

    localparam int WAIT_STATES = 2;     // idle cycles before ack.

    // counter wide enough to reach WAIT_STATES.
    localparam int WAIT_CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    localparam string MEM_INIT_FILE = "mem_init.hex";

    typedef logic [MEM_AW-1:0]  mem_idx_t;
    typedef logic [WAIT_CW-1:0] wait_cnt_t;

    // request to memory. rd and wr are levels, addr and wdata stay stable.
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rd;
        logic  wr;
    } mem_req_t;

    typedef struct packed {
        logic  ack;     // one cycle pulse that ends the access.
        word_t rdata;   // valid with ack.
    } mem_rsp_t;

endpackage
